//--- design/obj_cpu_port.sv
// Wishbone classic slave for the object engine with offset and arm registers
module obj_cpu_port #(
    parameter int  OBJ_COUNT = 32,
    localparam int AW        = $clog2(OBJ_COUNT * obj_pkg::WORDS_PER_OBJ)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [8:0]       adr,
    input  logic [15:0]      dat_i,
    output logic [15:0]      dat_o,
    output logic             ack,
    output logic             ram_we,
    output logic [AW-1:0]    ram_addr,
    output logic [15:0]      ram_wdata,
    input  logic [15:0]      ram_rdata,
    output video_pkg::hpos_t xoffset,
    output video_pkg::vpos_t yoffset,
    output logic             arm,
    input  logic             arm_clr
);
    import obj_pkg::*;

    logic req;      // cycle seen, not yet acknowledged
    logic ram_sel;
    logic reg_we;

    assign req     = cyc & stb & ~ack;
    assign ram_sel = 32'(adr) < OBJ_COUNT * WORDS_PER_OBJ;
    assign reg_we  = req & we & ~ram_sel;

    assign ram_we    = req & we & ram_sel;
    assign ram_addr  = adr[AW-1:0];
    assign ram_wdata = dat_i;

    // staging RAM data arrives in the ack cycle, adr is held by the master
    always_comb begin
        dat_o = '0;
        if (ram_sel) begin
            dat_o = ram_rdata;
        end else begin
            case (adr)
                REG_XOFF: dat_o = {7'd0, xoffset};
                REG_YOFF: dat_o = {7'd0, yoffset};
                REG_ARM:  dat_o = {15'd0, arm};
                default:  dat_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack     <= 1'b0;
            xoffset <= '0;
            yoffset <= '0;
            arm     <= 1'b0;
        end else begin
            ack <= req;
            if (arm_clr) arm <= 1'b0;   // copy has started
            if (reg_we) begin
                case (adr)
                    REG_XOFF: xoffset <= dat_i[8:0];
                    REG_YOFF: yoffset <= dat_i[8:0];
                    REG_ARM:  arm     <= 1'b1;  // data ignored
                    default:  ;
                endcase
            end
        end
    end

endmodule

//--- design/obj_draw.sv
// object drawer, fetches tile rows from ROM and fills the double line buffer
module obj_draw (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  logic                hs,
    input  video_pkg::hpos_t    hdump,
    obj_draw_if.drawer          dr,
    output logic                rom_cs,
    output obj_pkg::rom_addr_t  rom_addr,
    input  logic                rom_ok,
    input  logic [31:0]         rom_data,
    output video_pkg::obj_pxl_t pxl
);
    import video_pkg::*;
    import obj_pkg::*;

    localparam obj_pxl_t BLANK = '{prio: 3'd0, pal: 7'd0, color: TRANSPARENT};

    typedef enum logic [1:0] {D_IDLE, D_FETCH, D_WRITE} dstate_t;

    dstate_t     state;
    logic        hs_l;
    logic        wr_bank;
    logic        half;          // second ROM word of a 16 wide row
    logic [2:0]  cnt;
    logic [31:0] row_data;
    obj_code_t   code;
    hpos_t       xpos;
    logic [3:0]  row;
    logic        size;
    logic        hflip;
    logic [6:0]  pal;
    logic [2:0]  prio;
    logic [3:0]  col;
    logic [3:0]  nibble;
    hpos_t       px_x;
    logic        px_we;
    obj_pxl_t    line_buf [2][512];

    assign rom_addr = rom_addr_of(code, row, half);
    assign col      = {half, cnt};                      // tile column
    assign nibble   = row_data[{cnt, 2'b00} +: 4];      // leftmost pixel in low nibble
    assign px_x     = xpos + 9'(hflip ? (size ? 4'd7 : 4'd15) - col : col);

    // earlier objects keep their pixels
    assign px_we = state == D_WRITE && nibble != TRANSPARENT
                   && line_buf[wr_bank][px_x].color == TRANSPARENT;

    always_ff @(posedge clk) begin
        if (px_we) line_buf[wr_bank][px_x] <= '{prio: prio, pal: pal, color: nibble};
        if (pxl_cen) line_buf[~wr_bank][hdump] <= BLANK;   // cleared once shown
    end

    always_ff @(posedge clk) begin
        if (state == D_FETCH && rom_ok) row_data <= rom_data;
        if (state == D_IDLE && dr.draw) begin
            code  <= dr.code;
            xpos  <= dr.xpos;
            row   <= dr.row;
            size  <= dr.size;
            hflip <= dr.hflip;
            pal   <= dr.pal;
            prio  <= dr.prio;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= D_IDLE;
            hs_l    <= 1'b0;
            wr_bank <= 1'b0;
            half    <= 1'b0;
            cnt     <= '0;
            rom_cs  <= 1'b0;
            dr.busy <= 1'b0;
            pxl     <= BLANK;
        end else begin
            hs_l <= hs;
            if (pxl_cen) pxl <= line_buf[~wr_bank][hdump];
            case (state)
                D_IDLE: begin
                    if (dr.draw) begin
                        dr.busy <= 1'b1;
                        rom_cs  <= 1'b1;
                        half    <= 1'b0;
                        state   <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        cnt    <= '0;
                        state  <= D_WRITE;
                    end
                end
                D_WRITE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 3'd7) begin
                        if (!size && !half) begin
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            state  <= D_FETCH;
                        end else begin
                            dr.busy <= 1'b0;
                            state   <= D_IDLE;
                        end
                    end
                end
                default: state <= D_IDLE;
            endcase
            if (hs && !hs_l) begin      // swap, unfinished object is lost
                wr_bank <= ~wr_bank;
                state   <= D_IDLE;
                rom_cs  <= 1'b0;
                dr.busy <= 1'b0;
            end
        end
    end

endmodule

//--- design/obj_draw_if.sv
// draw request channel from the object scanner to the object drawer
interface obj_draw_if;
    import video_pkg::*;
    import obj_pkg::*;

    logic       draw;       // single cycle request
    logic       busy;
    obj_code_t  code;
    hpos_t      xpos;       // offset already added
    logic [3:0] row;        // tile row after vflip
    logic       size;
    logic       hflip;
    logic [6:0] pal;
    logic [2:0] prio;

    modport scanner (
        output draw, code, xpos, row, size, hflip, pal, prio,
        input  busy
    );

    modport drawer (
        input  draw, code, xpos, row, size, hflip, pal, prio,
        output busy
    );
endinterface

//--- design/obj_pkg.sv
// object entry layout, object RAM sizing and CPU register map of the sprite engine
package obj_pkg;

    typedef logic [10:0] obj_code_t;    // tile code

    // word 0 holds the vertical placement and the attributes
    typedef struct packed {
        logic       enable;
        logic [2:0] prio;
        logic       hflip;
        logic       vflip;
        logic       size;               // 1 selects 8x8
        logic [8:0] y;
    } obj_w0_t;

    typedef struct packed {
        logic [6:0] pal;
        logic [8:0] x;
    } obj_w1_t;

    typedef struct packed {
        logic [4:0] spare;
        obj_code_t  code;
    } obj_w2_t;

    // word 3 carries nothing
    typedef struct packed {
        obj_w2_t w2;
        obj_w1_t w1;
        obj_w0_t w0;
    } obj_entry_t;

    localparam int WORDS_PER_OBJ = 4;

    localparam logic [8:0] REG_XOFF = 9'h100;
    localparam logic [8:0] REG_YOFF = 9'h101;
    localparam logic [8:0] REG_ARM  = 9'h102;

    typedef logic [15:0] rom_addr_t;    // code * 32 + row * 2 + half

    function automatic rom_addr_t rom_addr_of(obj_code_t code, logic [3:0] row, logic half);
        return {code, row, half};
    endfunction

endpackage

//--- design/obj_ram.sv
// two bank object RAM, staging bank copied to the active bank in vertical blank
module obj_ram #(
    parameter int  OBJ_COUNT = 32,
    localparam int DEPTH     = OBJ_COUNT * obj_pkg::WORDS_PER_OBJ,
    localparam int AW        = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             lvbl,
    input  logic             arm,
    output logic             arm_clr,
    input  logic             ram_we,
    input  logic [AW-1:0]    ram_addr,
    input  logic [15:0]      ram_wdata,
    output logic [15:0]      ram_rdata,
    input  logic [AW-1:0]    scan_addr,
    output logic [15:0]      scan_data,
    input  video_pkg::hpos_t xoffset_in,
    input  video_pkg::vpos_t yoffset_in,
    output video_pkg::hpos_t xoffset,
    output video_pkg::vpos_t yoffset
);
    logic [15:0]   stage_mem  [DEPTH];
    logic [15:0]   active_mem [DEPTH];
    logic          lvbl_l;
    logic          vb_fall;
    logic          dma_bsy;
    logic [AW-1:0] dma_addr;
    logic          bank_ok;     // active bank holds a full copy

    assign vb_fall = lvbl_l & ~lvbl;
    assign arm_clr = vb_fall & arm;

    // CPU side of the staging bank
    always_ff @(posedge clk) begin
        if (ram_we) stage_mem[ram_addr] <= ram_wdata;
        ram_rdata <= stage_mem[ram_addr];
    end

    always_ff @(posedge clk) begin
        if (dma_bsy) active_mem[dma_addr] <= stage_mem[dma_addr];  // one word per clock
        scan_data <= bank_ok ? active_mem[scan_addr] : '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l   <= 1'b0;
            dma_bsy  <= 1'b0;
            dma_addr <= '0;
            bank_ok  <= 1'b0;
            xoffset  <= '0;
            yoffset  <= '0;
        end else begin
            lvbl_l <= lvbl;
            if (arm_clr) begin
                dma_bsy  <= 1'b1;
                dma_addr <= '0;
                xoffset  <= xoffset_in;     // offsets follow the copied frame
                yoffset  <= yoffset_in;
            end else if (dma_bsy) begin
                dma_addr <= dma_addr + 1'b1;
                if (dma_addr == AW'(DEPTH - 1)) begin
                    dma_bsy <= 1'b0;
                    bank_ok <= 1'b1;
                end
            end
        end
    end

endmodule

//--- design/obj_scan.sv
// object scanner, walks the active bank at each line start and requests draws
module obj_scan #(
    parameter int  OBJ_COUNT = 32,
    localparam int AW        = $clog2(OBJ_COUNT * obj_pkg::WORDS_PER_OBJ)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             hs,
    input  video_pkg::vpos_t vrender,
    output logic [AW-1:0]    scan_addr,
    input  logic [15:0]      scan_data,
    input  video_pkg::hpos_t xoffset,
    input  video_pkg::vpos_t yoffset,
    obj_draw_if.scanner      dr
);
    import video_pkg::*;
    import obj_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_W0, S_W1, S_W2, S_W3, S_DRAW} state_t;

    state_t        state;
    logic [AW-3:0] obj_idx;
    logic [1:0]    sub;
    logic          hs_l;
    logic          last;
    obj_w0_t       w0;
    obj_w1_t       w1;
    obj_w2_t       w2;
    vpos_t         ydiff;
    logic          inzone;
    logic [3:0]    row;

    // RAM read has one cycle of latency, word n is seen one state later
    assign sub       = state == S_W1 ? 2'd1 : state == S_W2 ? 2'd2 : 2'd0;
    assign scan_addr = {obj_idx, sub};
    assign last      = obj_idx == (AW-2)'(OBJ_COUNT - 1);

    assign w0 = obj_w0_t'(scan_data);
    assign w1 = obj_w1_t'(scan_data);
    assign w2 = obj_w2_t'(scan_data);

    always_comb begin
        ydiff  = vrender + 9'd1 - w0.y - yoffset;   // next line, wraps at 512
        inzone = w0.enable && (w0.size ? ydiff[8:3] == '0 : ydiff[8:4] == '0);
        if (w0.size) begin
            row = {1'b0, ydiff[2:0] ^ {3{w0.vflip}}};
        end else begin
            row = ydiff[3:0] ^ {4{w0.vflip}};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            obj_idx <= '0;
            hs_l    <= 1'b0;
            dr.draw <= 1'b0;
        end else begin
            hs_l    <= hs;
            dr.draw <= 1'b0;
            case (state)
                S_W0: state <= S_W1;
                S_W1: begin
                    if (inzone) begin
                        state <= S_W2;
                    end else if (last) begin
                        state <= S_IDLE;
                    end else begin
                        obj_idx <= obj_idx + 1'b1;
                        state   <= S_W0;
                    end
                end
                S_W2: state <= S_W3;
                S_W3: state <= S_DRAW;
                S_DRAW: begin
                    if (!dr.busy) begin     // held while the drawer works
                        dr.draw <= 1'b1;
                        if (last) begin
                            state <= S_IDLE;
                        end else begin
                            obj_idx <= obj_idx + 1'b1;
                            state   <= S_W0;
                        end
                    end
                end
                default: ;
            endcase
            if (hs && !hs_l) begin      // restart, pending object dropped
                state   <= S_W0;
                obj_idx <= '0;
                dr.draw <= 1'b0;
            end
        end
    end

    // request fields, latched by the drawer on draw
    always_ff @(posedge clk) begin
        case (state)
            S_W1: begin
                dr.row   <= row;
                dr.size  <= w0.size;
                dr.hflip <= w0.hflip;
                dr.prio  <= w0.prio;
            end
            S_W2: begin
                dr.xpos <= w1.x + xoffset;
                dr.pal  <= w1.pal;
            end
            S_W3: dr.code <= w2.code;
            default: ;
        endcase
    end

endmodule

//--- design/obj_top.sv
// sprite engine top level, CPU port, object RAM, scanner and drawer
module obj_top #(
    parameter int  OBJ_COUNT = 32,
    localparam int AW        = $clog2(OBJ_COUNT * obj_pkg::WORDS_PER_OBJ)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [8:0]          adr,
    input  logic [15:0]         dat_i,
    output logic [15:0]         dat_o,
    output logic                ack,
    input  logic                hs,
    input  logic                lvbl,
    input  video_pkg::vpos_t    vrender,
    input  video_pkg::hpos_t    hdump,
    input  logic                pxl_cen,
    output logic                rom_cs,
    output obj_pkg::rom_addr_t  rom_addr,
    input  logic                rom_ok,
    input  logic [31:0]         rom_data,
    output video_pkg::obj_pxl_t pxl
);
    import video_pkg::*;

    logic          ram_we;
    logic [AW-1:0] ram_addr;
    logic [15:0]   ram_wdata;
    logic [15:0]   ram_rdata;
    logic [AW-1:0] scan_addr;
    logic [15:0]   scan_data;
    hpos_t         pre_xoff;    // CPU written
    vpos_t         pre_yoff;
    hpos_t         xoffset;     // latched in blanking
    vpos_t         yoffset;
    logic          arm;
    logic          arm_clr;

    obj_draw_if u_draw_if ();

    obj_cpu_port #(.OBJ_COUNT(OBJ_COUNT)) u_cpu_port (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_i     (dat_i),
        .dat_o     (dat_o),
        .ack       (ack),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .xoffset   (pre_xoff),
        .yoffset   (pre_yoff),
        .arm       (arm),
        .arm_clr   (arm_clr)
    );

    obj_ram #(.OBJ_COUNT(OBJ_COUNT)) u_ram (
        .clk        (clk),
        .rst        (rst),
        .lvbl       (lvbl),
        .arm        (arm),
        .arm_clr    (arm_clr),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .scan_addr  (scan_addr),
        .scan_data  (scan_data),
        .xoffset_in (pre_xoff),
        .yoffset_in (pre_yoff),
        .xoffset    (xoffset),
        .yoffset    (yoffset)
    );

    obj_scan #(.OBJ_COUNT(OBJ_COUNT)) u_scan (
        .clk       (clk),
        .rst       (rst),
        .hs        (hs),
        .vrender   (vrender),
        .scan_addr (scan_addr),
        .scan_data (scan_data),
        .xoffset   (xoffset),
        .yoffset   (yoffset),
        .dr        (u_draw_if.scanner)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .hdump    (hdump),
        .dr       (u_draw_if.drawer),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .pxl      (pxl)
    );

endmodule

//--- design/video_pkg.sv
// raster position types and the object pixel format of the video path
package video_pkg;

    // horizontal pixel position as counted by hdump
    typedef logic [8:0] hpos_t;

    // line number as counted by vrender
    typedef logic [8:0] vpos_t;

    // one object layer pixel
    typedef struct packed {
        logic [2:0] prio;
        logic [6:0] pal;
        logic [3:0] color;
    } obj_pxl_t;

    localparam logic [3:0] TRANSPARENT = 4'hf;  // never stored by the drawer

endpackage

//--- run.sh
#!/bin/sh
# build and run the sprite engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module obj_tb \
    -Mdir obj_build -o obj_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_build/obj_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

//--- sim.f
design/video_pkg.sv
design/obj_pkg.sv
design/obj_draw_if.sv
design/obj_cpu_port.sv
design/obj_ram.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_top.sv
tb/obj_chk.sv
tb/obj_tb.sv

//--- tb/obj_chk.sv
// handshake assertions for the sprite engine, bound into the top level
module obj_chk (
    input logic               clk,
    input logic               rst,
    input logic               ack,
    input logic               rom_cs,
    input logic               rom_ok,
    input obj_pkg::rom_addr_t rom_addr,
    input logic               draw,
    input logic               busy
);
    timeunit 1ns;
    timeprecision 100ps;

    // Wishbone ack is a one cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack held for more than one cycle");

    // address held until the ROM answers or the fetch is dropped at hs
    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> !rom_cs || $stable(rom_addr))
        else $error("rom_addr changed while a ROM read was pending");

    draw_idle: assert property (@(posedge clk) disable iff (rst) draw |-> !busy)
        else $error("draw request issued while the drawer was busy");

endmodule

bind obj_top obj_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .ack      (ack),
    .rom_cs   (rom_cs),
    .rom_ok   (rom_ok),
    .rom_addr (rom_addr),
    .draw     (u_draw_if.draw),
    .busy     (u_draw_if.busy)
);

//--- tb/obj_tb.sv
// testbench for the sprite engine with raster generator, ROM model and directed tests
module obj_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import video_pkg::*;
    import obj_pkg::*;

    localparam int      OBJ_COUNT   = 32;
    localparam int      WORDS       = OBJ_COUNT * WORDS_PER_OBJ;
    localparam int      LINE_CLKS   = 320;
    localparam int      LINES       = 262;
    localparam int      HS_END      = 8;
    localparam int      VIS_START   = 24;
    localparam int      VIS_LEN     = 288;
    localparam int      FRAME_CLKS  = LINE_CLKS * LINES;
    localparam int      TEST_FRAMES = 10;       // frames spent by all tests together
    localparam realtime CLK_PERIOD  = 100ns;

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [8:0]  adr;
    logic [15:0] dat_i;
    logic [15:0] dat_o;
    logic        ack;
    logic        hs;
    logic        lvbl;
    vpos_t       vrender;
    hpos_t       hdump;
    logic        pxl_cen;
    logic        rom_cs;
    rom_addr_t   rom_addr;
    logic        rom_ok;
    logic [31:0] rom_data;
    obj_pxl_t    pxl;

    int          hcnt;
    int          vcnt;
    logic        vis;
    hpos_t       seen_x;        // hdump as sampled by the DUT
    vpos_t       seen_line;
    logic        seen_vis;
    int          rom_cnt;
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          see_through;
    logic [15:0] stage_w [WORDS];
    logic [15:0] act_w [WORDS];
    hpos_t       pre_xoff;
    vpos_t       pre_yoff;
    hpos_t       act_xoff;
    vpos_t       act_yoff;

    obj_top #(.OBJ_COUNT(OBJ_COUNT)) u_obj_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * FRAME_CLKS * (TEST_FRAMES + 2));
        $display("timeout, tests did not finish within %0d frames", TEST_FRAMES + 2);
        $display("Test failed");
        $finish;
    end

    // galois LFSR stepped once per bit taken
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'ha300_0000 : lfsr >> 1;
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    // ROM content as 8 nibbles stepping by 3 from a base taken from the whole address
    function automatic logic [31:0] rom_word(input rom_addr_t a);
        logic [31:0] w;
        logic [3:0]  base;
        base = a[3:0] + a[7:4] + a[11:8] + a[15:12];
        for (int i = 0; i < 8; i++) w[i*4 +: 4] = base + 4'(3 * i);
        return w;
    endfunction

    // raster with hs at line start, visible hdump 0..287 and blank lines 240..261
    always @(posedge clk) begin
        logic vis_n;
        seen_x    <= hdump;
        seen_line <= vrender;
        seen_vis  <= vis;
        if (!rst) begin
            hcnt = hcnt + 1;
            if (hcnt == LINE_CLKS) begin
                hcnt = 0;
                vcnt = vcnt == LINES - 1 ? 0 : vcnt + 1;
            end
        end
        vis_n   = hcnt >= VIS_START && hcnt < VIS_START + VIS_LEN;
        vis     <= vis_n;
        hs      <= hcnt < HS_END;
        hdump   <= vis_n ? 9'(hcnt - VIS_START) : 9'h1ff;  // parked where no object draws
        vrender <= 9'(vcnt);
        lvbl    <= vcnt < 240;
    end

    // ROM model answering after 1 to 4 cycles
    always @(posedge clk) begin
        if (rst) begin
            rom_ok  <= 1'b0;
            rom_cnt <= 0;
        end else begin
            rom_ok <= 1'b0;
            if (rom_cs && !rom_ok) begin
                if (rom_cnt == 0) begin
                    rom_cnt <= 1 + rand_bits(2);
                end else if (rom_cnt == 1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                    rom_cnt  <= 0;
                end else begin
                    rom_cnt <= rom_cnt - 1;
                end
            end else begin
                rom_cnt <= 0;
            end
        end
    end

    // first opaque pixel of the lowest object index covering (line, x)
    function automatic obj_pxl_t expect_pxl(input int line, input int x);
        obj_pxl_t    p;
        logic [15:0] w0;
        logic [15:0] w1;
        logic [15:0] w2;
        int          h;
        int          dy;
        int          dx;
        int          row;
        int          col;
        logic [31:0] word;
        logic [3:0]  nib;
        logic        covered;
        p = '{prio: 3'd0, pal: 7'd0, color: TRANSPARENT};
        covered = 1'b0;
        for (int i = 0; i < OBJ_COUNT; i++) begin
            w0 = act_w[i*4];
            w1 = act_w[i*4 + 1];
            w2 = act_w[i*4 + 2];
            h  = w0[9] ? 8 : 16;
            dy = (line - int'(w0[8:0]) - int'(act_yoff)) & 511;
            dx = (x - int'(w1[8:0]) - int'(act_xoff)) & 511;
            if (w0[15] && p.color == TRANSPARENT && dy < h && dx < h) begin
                row  = w0[10] ? h - 1 - dy : dy;
                col  = w0[11] ? h - 1 - dx : dx;
                word = rom_word(16'(int'(w2[10:0]) * 32 + row * 2 + col / 8));
                nib  = word[(col % 8) * 4 +: 4];
                if (nib != TRANSPARENT) begin
                    if (covered) see_through++;
                    p = '{prio: w0[14:12], pal: w1[15:9], color: nib};
                end else begin
                    covered = 1'b1;
                end
            end
        end
        return p;
    endfunction

    task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pxl(input obj_pxl_t got, input obj_pxl_t exp, input int line,
                             input int x);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t pxl line %0d x %0d got %h expected %h", $time, line, x, got, exp);
        end
    endtask

    task automatic wait_ack;
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack && n < 16);
        if (!ack) begin
            errors++;
            $display("no Wishbone ack within 16 cycles at %0t", $time);
        end
    endtask

    task automatic wb_write(input logic [8:0] a, input logic [15:0] d);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_i <= d;
        wait_ack();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        if (int'(a) < WORDS) stage_w[a] = d;
        if (a == REG_XOFF) pre_xoff = d[8:0];
        if (a == REG_YOFF) pre_yoff = d[8:0];
    endtask

    task automatic wb_read(input logic [8:0] a, output logic [15:0] d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        wait_ack();
        d = dat_o;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic put_obj(input int idx, input int x, input int y, input int code,
                           input int pal, input int prio, input logic size,
                           input logic vflip, input logic hflip);
        wb_write(9'(idx * 4), {1'b1, 3'(prio), hflip, vflip, size, 9'(y)});
        wb_write(9'(idx * 4 + 1), {7'(pal), 9'(x)});
        wb_write(9'(idx * 4 + 2), {5'd0, 11'(code)});
    endtask

    // model of the vertical-blank copy
    task automatic take_copy;
        act_w    = stage_w;
        act_xoff = pre_xoff;
        act_yoff = pre_yoff;
    endtask

    task automatic wait_line(input int line);
        do @(negedge clk); while (int'(seen_line) != line);
    endtask

    task automatic check_lines(input int first, input int last);
        wait_line(first);
        while (int'(seen_line) >= first && int'(seen_line) <= last) begin
            if (seen_vis) begin
                check_pxl(pxl, expect_pxl(int'(seen_line), int'(seen_x)),
                          int'(seen_line), int'(seen_x));
            end
            @(negedge clk);
        end
    endtask

    task automatic test_readback;
        logic [15:0] d;
        wb_write(REG_XOFF, 16'h0123);
        wb_write(REG_YOFF, 16'h00a5);
        for (int i = 0; i < 8; i++) wb_write(9'(i * 13), 16'(16'h3c5a ^ (i * 16'h1111)));
        wb_read(REG_XOFF, d);
        check_word(d, 16'h0123, "dat_o xoffset");
        wb_read(REG_YOFF, d);
        check_word(d, 16'h00a5, "dat_o yoffset");
        for (int i = 0; i < 8; i++) begin
            wb_read(9'(i * 13), d);
            check_word(d, 16'(16'h3c5a ^ (i * 16'h1111)), "dat_o staging word");
        end
        wb_write(REG_XOFF, 16'h0000);
        wb_write(REG_YOFF, 16'h0000);
    endtask

    task automatic test_single;
        wait_line(5);
        for (int i = 0; i < WORDS; i++) wb_write(9'(i), 16'h0000);
        put_obj(0, 40, 50, 11'h005, 7'h2a, 3, 1'b0, 1'b0, 1'b0);
        wb_write(REG_ARM, 16'h0001);
        take_copy();
        check_lines(1, 239);
    endtask

    task automatic test_no_arm;
        wait_line(5);
        put_obj(0, 60, 70, 11'h009, 7'h15, 4, 1'b0, 1'b0, 1'b0);   // staging only
        check_lines(1, 239);    // frame after a blanking without arm
    endtask

    task automatic test_flips;
        wait_line(5);
        put_obj(1, 100, 80, 11'h012, 7'h11, 1, 1'b0, 1'b1, 1'b1);
        put_obj(2, 150, 120, 11'h020, 7'h33, 2, 1'b1, 1'b0, 1'b1);
        put_obj(3, 200, 30, 11'h031, 7'h44, 5, 1'b1, 1'b1, 1'b0);
        wb_write(REG_ARM, 16'h0001);
        take_copy();
        check_lines(1, 239);
    endtask

    task automatic test_overlap;
        wait_line(5);
        put_obj(4, 108, 86, 11'h040, 7'h55, 6, 1'b0, 1'b0, 1'b0);  // under object 1
        wb_write(REG_ARM, 16'h0001);
        take_copy();
        see_through = 0;
        check_lines(1, 239);
        if (see_through == 0) begin
            errors++;
            $display("overlap test saw no place where a higher object showed through");
        end
    endtask

    task automatic test_offsets;
        wait_line(50);
        wb_write(REG_XOFF, 16'h0007);
        wb_write(REG_YOFF, 16'h0003);
        wb_write(REG_ARM, 16'h0001);
        check_lines(60, 239);   // old offsets until blanking
        take_copy();
        check_lines(1, 239);
    endtask

    initial begin
        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_i    = '0;
        hs       = 1'b0;
        lvbl     = 1'b1;
        vrender  = '0;
        hdump    = 9'h1ff;
        pxl_cen  = 1'b1;
        rom_ok   = 1'b0;
        rom_data = '0;
        hcnt     = 0;
        vcnt     = 0;
        vis      = 1'b0;
        lfsr     = 32'h4eff_6a52;
        errors   = 0;
        checks   = 0;
        pre_xoff = '0;
        pre_yoff = '0;
        act_xoff = '0;
        act_yoff = '0;
        for (int i = 0; i < WORDS; i++) act_w[i] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_readback();
        test_single();
        test_no_arm();
        test_flips();
        test_overlap();
        test_offsets();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
